// File: Makefile
# Verilator flow for the decode stage testbench

TOP = decodeStageTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

# The log is searched for the pass line, so a failing run returns an error
sim:
	rm -f sim.log
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim.f
source/isaPkg.sv
source/stagePkg.sv
source/instrFields.sv
source/registerFile.sv
source/branchResolve.sv
source/linkTracker.sv
source/decodeStage.sv
tb/decodeStageTb.sv

// File: source/branchResolve.sv
/* Branch condition evaluation on the Rs value and the PC-select strobe */
`default_nettype none
module branchResolve
   import isaPkg::*, stagePkg::*;
(
   input instrClass_t fields,
   input word_t rsData,
   input logic instrValid,
   output logic pcSel
);

   logic zeroFlag;
   logic signFlag;
   logic branchTaken;

   // Conditions only look at Rs, compared against zero
   assign zeroFlag = (rsData == '0);
   assign signFlag = rsData[$bits(word_t)-1];

   always_comb begin
      case (fields.cond)
         // BEQZ branches when Rs is zero
         2'b00: branchTaken = zeroFlag;
         // BNEZ branches when Rs is anything else
         2'b01: branchTaken = !zeroFlag;
         // BLTZ branches on a negative Rs
         2'b10: branchTaken = signFlag;
         // BGEZ branches when Rs is zero or positive
         default: branchTaken = !signFlag;
      endcase
   end

   // Jumps always redirect, branches only when their condition holds
   // A bubble in decode must never move the PC
   assign pcSel = instrValid && (fields.isJump || (fields.isBranch && branchTaken));

endmodule
`default_nettype wire

// File: source/decodeStage.sv
/* Top of the decode stage: field split, register file, branch resolution,
   link write-through and link tracking toward writeback */
`default_nettype none
module decodeStage
   import isaPkg::*, stagePkg::*;
#(
   parameter int WbDistance = 3
) (
   input logic clk,
   input logic reset,
   input word_t instr,
   input word_t pcNow,
   input logic instrValid,
   input wbWrite_t wbIn,
   output decodeOut_t decodeOut
);

   instrClass_t fields;
   word_t rsData;
   word_t rtData;
   logic pcSel;

   // Link handling
   word_t linkData;
   logic linkWrite;
   logic wbIsLink;
   wbWrite_t wbGated;

   // Split the instruction into register numbers, condition and class
   instrFields i_instrFields (
      .instr(instr),
      .fields(fields)
   );

   // Return address of a jump-and-link is the instruction after it
   assign linkData = pcNow + InstrBytes;

   // A link writes its return address while still in decode
   // Bubbles must not touch the register file
   assign linkWrite = instrValid && fields.isLink;

   // The link instruction reaches writeback later with the same r7 write
   // That copy is dropped; every other writeback passes unchanged
   always_comb begin
      wbGated = wbIn;
      wbGated.valid = wbIn.valid && !wbIsLink;
   end

   registerFile i_registerFile (
      .clk(clk),
      .reset(reset),
      .rsAddr(fields.rs),
      .rtAddr(fields.rt),
      .wbWrite(wbGated),
      .linkWrite(linkWrite),
      .linkData(linkData),
      .rsData(rsData),
      .rtData(rtData)
   );

   // Branch conditions use the bypassed Rs value of this same cycle
   branchResolve i_branchResolve (
      .fields(fields),
      .rsData(rsData),
      .instrValid(instrValid),
      .pcSel(pcSel)
   );

   // Marks which later stage carries a link, so its writeback can be dropped
   linkTracker #(
      .WbDistance(WbDistance)
   ) i_linkTracker (
      .clk(clk),
      .reset(reset),
      .linkIssued(linkWrite),
      .wbIsLink(wbIsLink)
   );

   // All outputs are combinational in the decode cycle
   always_comb begin
      decodeOut.rsData = rsData;
      decodeOut.rtData = rtData;
      decodeOut.pcSel = pcSel;
   end

endmodule
`default_nettype wire

// File: source/instrFields.sv
/* Field extraction and classification of the instruction in decode */
`default_nettype none
module instrFields
   import isaPkg::*, stagePkg::*;
(
   input word_t instr,
   output instrClass_t fields
);

   opcode_t opcode;

   // The major opcode always occupies the top five bits
   assign opcode = instr[15:11];

   // Register numbers sit at fixed positions for every format
   // Instructions without one of the operands simply read a register they ignore
   assign fields.rs = instr[10:8];
   assign fields.rt = instr[7:5];

   // For branches the two low opcode bits double as the condition code
   assign fields.cond = instr[12:11];

   // Branches are identified by their three-bit prefix
   assign fields.isBranch = (instr[15:13] == BranchPrefix);

   always_comb begin
      // All four jump forms redirect the PC without a condition
      case (opcode)
         OpJ,
         OpJr,
         OpJal,
         OpJalr: fields.isJump = 1'b1;
         default: fields.isJump = 1'b0;
      endcase
   end

   always_comb begin
      // Only the linking forms write the return address
      case (opcode)
         OpJal,
         OpJalr: fields.isLink = 1'b1;
         default: fields.isLink = 1'b0;
      endcase
   end

endmodule
`default_nettype wire

// File: source/isaPkg.sv
/* ISA-level types for the 16-bit core: word, register number and opcode widths,
   the jump opcode constants, the branch prefix, the link register and the PC step */
package isaPkg;

   // A data word and an instruction address share the same width
   typedef logic [15:0] word_t;

   // Eight architectural registers need a 3-bit number
   typedef logic [2:0] regAddr_t;

   // The major opcode sits in the top five bits of every instruction
   typedef logic [4:0] opcode_t;

   // Number of architectural registers held by the register file
   localparam int NumRegs = 8;

   // Unconditional jumps share the 001 prefix and differ in the low two bits
   // Bit 0 selects a register target, bit 1 selects the linking form
   localparam opcode_t OpJ = 5'b00100;
   localparam opcode_t OpJr = 5'b00101;
   localparam opcode_t OpJal = 5'b00110;
   localparam opcode_t OpJalr = 5'b00111;

   // Conditional branches are recognized by the top three opcode bits alone
   // The next two bits then carry the condition code
   localparam logic [2:0] BranchPrefix = 3'b011;

   // Jump-and-link always deposits its return address here
   localparam regAddr_t LinkReg = 3'd7;

   // Every instruction is one word long, so the next PC is two bytes on
   localparam word_t InstrBytes = 16'd2;

endpackage

// File: source/linkTracker.sv
/* Shift chain that follows link instructions from decode down to writeback */
`default_nettype none
module linkTracker #(
   parameter int WbDistance = 3
) (
   input logic clk,
   input logic reset,
   input logic linkIssued,
   output logic wbIsLink
);

   // One bit per later stage; bit 0 is the stage right after decode
   logic [WbDistance-1:0] inFlight;

   // The chain advances every cycle since the pipeline never stalls
   // A new link enters at bit 0 and moves up one stage per cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         inFlight <= '0;
      end else begin
         inFlight <= (inFlight << 1) | WbDistance'(linkIssued);
      end
   end

   // The top bit belongs to the instruction now in writeback
   // When it is set, that instruction already wrote the link register from decode
   assign wbIsLink = inFlight[WbDistance-1];

endmodule
`default_nettype wire

// File: source/registerFile.sv
/* Eight 16-bit registers with two bypassed read ports, a writeback write port
   and a dedicated link write port that always targets the link register */
`default_nettype none
module registerFile
   import isaPkg::*, stagePkg::*;
(
   input logic clk,
   input logic reset,
   input regAddr_t rsAddr,
   input regAddr_t rtAddr,
   input wbWrite_t wbWrite,
   input logic linkWrite,
   input word_t linkData,
   output word_t rsData,
   output word_t rtData
);

   word_t regs [NumRegs];

   // Both write ports update at the clock edge
   // The link write comes last so it wins when both target the link register
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wbWrite.valid) begin
            regs[wbWrite.addr] <= wbWrite.data;
         end
         if (linkWrite) begin
            regs[LinkReg] <= linkData;
         end
      end
   end

   // Read with write-before-read bypass, checked in the same order as the writes
   function automatic word_t readPort(input regAddr_t addr);
      word_t value;
      value = regs[addr];
      if (wbWrite.valid && (wbWrite.addr == addr)) begin
         value = wbWrite.data;
      end
      // A link in decode overrides any older writeback to the same register
      if (linkWrite && (addr == LinkReg)) begin
         value = linkData;
      end
      return value;
   endfunction

   always_comb begin
      rsData = readPort(rsAddr);
      rtData = readPort(rtAddr);
   end

endmodule
`default_nettype wire

// File: source/stagePkg.sv
/* Packed structs passed between the pipeline stages and the decode block:
   writeback request, decoded instruction class and the decode outputs */
package stagePkg;

   import isaPkg::*;

   // Write request coming back from the writeback stage
   // Its data is final and goes straight into the register file
   typedef struct packed {
      logic valid;
      regAddr_t addr;
      word_t data;
   } wbWrite_t;

   // Fields and flags pulled out of the instruction in decode
   typedef struct packed {
      logic isBranch;
      logic isJump;
      logic isLink;
      // Only branches use this condition code
      logic [1:0] cond;
      regAddr_t rs;
      regAddr_t rt;
   } instrClass_t;

   // What decode hands to the rest of the pipeline
   typedef struct packed {
      word_t rsData;
      word_t rtData;
      // High when fetch must take the branch or jump target
      logic pcSel;
   } decodeOut_t;

endpackage

// File: tb/decodeStageTb.sv
/* Vector-driven testbench for the decode stage: clock and reset, stimulus
   read from the test data file, output checks, per-test lines and the verdict */
module decodeStageTb
   import isaPkg::*, stagePkg::*;
();

   localparam int ClkPeriod = 40;
   localparam int ResetCycles = 10;
   localparam int WbDistance = 3;
   // Each vector line carries ten hex fields
   localparam int FieldsPerVec = 10;
   localparam int MaxVectors = 256;
   // Slack cycles beyond reset and the vectors before the run is declared hung
   localparam int TimeoutMargin = 20;
   // A test number of ffff closes the vector list
   localparam logic [15:0] EndMarker = 16'hffff;

   logic clk;
   logic reset;
   word_t instr;
   word_t pcNow;
   logic instrValid;
   wbWrite_t wbIn;
   decodeOut_t decodeOut;

   // Flat image of the data file, one 16-bit word per field
   logic [15:0] vecMem [FieldsPerVec*MaxVectors];

   int numVectors;
   int cycleCount = 0;
   int cycleLimit;
   int currentTest;
   int testErrors;
   int testCycles;
   int totalErrors;
   int testsPassed;
   int testsFailed;

   decodeStage #(
      .WbDistance(WbDistance)
   ) i_dut (
      .clk(clk),
      .reset(reset),
      .instr(instr),
      .pcNow(pcNow),
      .instrValid(instrValid),
      .wbIn(wbIn),
      .decodeOut(decodeOut)
   );

   initial clk = 1'b0;
   always #(ClkPeriod / 2) clk = ~clk;

   // The watchdog counts rising edges against the limit set from the vector count
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout after %0d cycles, the vector run never completed", cycleCount);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // One field of one vector, taken from the flat memory
   function automatic logic [15:0] vecField(input int vecIdx, input int fieldIdx);
      return vecMem[vecIdx * FieldsPerVec + fieldIdx];
   endfunction

   // Vectors run up to the end marker or the memory size
   function automatic int countVectors();
      int count;
      count = 0;
      while (count < MaxVectors && vecMem[count * FieldsPerVec] != EndMarker) begin
         count++;
      end
      return count;
   endfunction

   // Fields 1 to 6 are the stage inputs for one cycle
   task automatic applyVector(input int vecIdx);
      logic [15:0] flagField;
      logic [15:0] addrField;
      instr = vecField(vecIdx, 1);
      pcNow = vecField(vecIdx, 2);
      flagField = vecField(vecIdx, 3);
      instrValid = flagField[0];
      flagField = vecField(vecIdx, 4);
      wbIn.valid = flagField[0];
      addrField = vecField(vecIdx, 5);
      wbIn.addr = addrField[2:0];
      wbIn.data = vecField(vecIdx, 6);
   endtask

   // Fields 7 to 9 are the expected read data and PC select
   task automatic checkVector(input int vecIdx);
      word_t expRs;
      word_t expRt;
      logic [15:0] pcSelField;
      expRs = vecField(vecIdx, 7);
      expRt = vecField(vecIdx, 8);
      pcSelField = vecField(vecIdx, 9);
      if (decodeOut.rsData !== expRs) begin
         $display("MISMATCH test %0d line %0d: rsData expected %h actual %h",
                  currentTest, vecIdx + 1, expRs, decodeOut.rsData);
         testErrors++;
      end
      if (decodeOut.rtData !== expRt) begin
         $display("MISMATCH test %0d line %0d: rtData expected %h actual %h",
                  currentTest, vecIdx + 1, expRt, decodeOut.rtData);
         testErrors++;
      end
      if (decodeOut.pcSel !== pcSelField[0]) begin
         $display("MISMATCH test %0d line %0d: pcSel expected %h actual %h",
                  currentTest, vecIdx + 1, pcSelField[0], decodeOut.pcSel);
         testErrors++;
      end
   endtask

   // One line per finished test, and its errors join the running total
   task automatic reportTest();
      if (testErrors == 0) begin
         testsPassed++;
         $display("Test %0d passed, %0d cycles", currentTest, testCycles);
      end else begin
         testsFailed++;
         $display("Test %0d failed, %0d mismatches in %0d cycles",
                  currentTest, testErrors, testCycles);
      end
      totalErrors += testErrors;
   endtask

   initial begin
      int testNum;
      reset = 1'b1;
      instr = '0;
      pcNow = '0;
      instrValid = 1'b0;
      wbIn = '0;
      currentTest = -1;
      testErrors = 0;
      testCycles = 0;
      totalErrors = 0;
      testsPassed = 0;
      testsFailed = 0;
      $readmemh("tb/decode_testdata.txt", vecMem);
      numVectors = countVectors();
      cycleLimit = numVectors + ResetCycles + TimeoutMargin;
      if (numVectors == 0) begin
         $display("No vectors were found in the test data file");
      end
      // Reset spans ten rising edges with a bubble and no writeback
      repeat (ResetCycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (int v = 0; v < numVectors; v++) begin
         testNum = int'(vecField(v, 0));
         // A new test number closes the previous test
         if (testNum != currentTest) begin
            if (currentTest >= 0) begin
               reportTest();
            end
            currentTest = testNum;
            testErrors = 0;
            testCycles = 0;
         end
         // Drive on the falling edge, sample just ahead of the rising edge
         applyVector(v);
         #(ClkPeriod / 2 - 1);
         checkVector(v);
         testCycles++;
         @(negedge clk);
      end
      if (currentTest >= 0) begin
         reportTest();
      end
      $display("Summary: %0d tests passed, %0d failed, %0d mismatches over %0d vectors",
               testsPassed, testsFailed, totalErrors, numVectors);
      if (numVectors > 0 && totalErrors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: tb/decode_testdata.txt
// test instr pcNow valid wbValid wbAddr wbData expRsData expRtData expPcSel
// All fields hex, one line per cycle; test number ffff ends the list
// Test 1: zero after reset, writebacks to all registers, readback on both ports
01 0020 0000 1 0 0 0000 0000 0000 0
01 0260 0000 1 0 0 0000 0000 0000 0
01 04a0 0000 1 0 0 0000 0000 0000 0
01 06e0 0000 1 0 0 0000 0000 0000 0
01 0000 0000 0 1 1 1001 0000 0000 0
01 0000 0000 0 1 2 2002 0000 0000 0
01 0000 0000 0 1 3 3003 0000 0000 0
01 0000 0000 0 1 4 4004 0000 0000 0
01 0000 0000 0 1 5 5005 0000 0000 0
01 0000 0000 0 1 6 6006 0000 0000 0
01 0000 0000 0 1 7 7007 0000 0000 0
01 0120 0000 0 1 0 a5a0 1001 1001 0
01 0020 0000 1 0 0 0000 a5a0 1001 0
01 0260 0000 1 0 0 0000 2002 3003 0
01 04a0 0000 1 0 0 0000 4004 5005 0
01 06e0 0000 1 0 0 0000 6006 7007 0
01 0700 0000 1 0 0 0000 7007 a5a0 0
01 03c0 0000 1 0 0 0000 3003 6006 0
// Test 2: same-cycle bypass on each read port
02 0240 0000 1 1 2 beef beef beef 0
02 0240 0000 1 0 0 0000 beef beef 0
02 0540 0000 1 1 5 c0de c0de beef 0
02 0260 0000 1 1 3 0bad beef 0bad 0
02 0560 0000 1 0 0 0000 c0de 0bad 0
// Test 3: branch conditions on zero, positive and negative Rs, then bubbles
03 0000 0000 0 1 4 0000 a5a0 a5a0 0
03 6400 0000 1 0 0 0000 0000 a5a0 1
03 6100 0000 1 0 0 0000 1001 a5a0 0
03 6000 0000 1 0 0 0000 a5a0 a5a0 0
03 6c00 0000 1 0 0 0000 0000 a5a0 0
03 6900 0000 1 0 0 0000 1001 a5a0 1
03 6800 0000 1 0 0 0000 a5a0 a5a0 1
03 7400 0000 1 0 0 0000 0000 a5a0 0
03 7100 0000 1 0 0 0000 1001 a5a0 0
03 7000 0000 1 0 0 0000 a5a0 a5a0 1
03 7c00 0000 1 0 0 0000 0000 a5a0 1
03 7900 0000 1 0 0 0000 1001 a5a0 1
03 7800 0000 1 0 0 0000 a5a0 a5a0 0
03 6400 0000 0 0 0 0000 0000 a5a0 0
03 6900 0000 0 0 0 0000 1001 a5a0 0
03 7000 0000 0 0 0 0000 a5a0 a5a0 0
03 7c00 0000 0 0 0 0000 0000 a5a0 0
// Test 4: J and JR redirect, a bubbled jump and other opcodes do not
04 2140 0000 1 0 0 0000 1001 beef 1
04 2940 0000 1 0 0 0000 1001 beef 1
04 2140 0000 0 0 0 0000 1001 beef 0
04 4140 0000 1 0 0 0000 1001 beef 0
04 8140 0000 1 0 0 0000 1001 beef 0
04 f940 0000 1 0 0 0000 1001 beef 0
04 1940 0000 1 0 0 0000 1001 beef 0
// Test 5: JAL and JALR link into r7, own writeback dropped, others land
05 3700 5a3e 1 0 0 0000 5a40 a5a0 1
05 0700 0000 1 0 0 0000 5a40 a5a0 0
05 0700 0000 1 0 0 0000 5a40 a5a0 0
05 0700 0000 1 1 7 dead 5a40 a5a0 0
05 0700 0000 1 0 0 0000 5a40 a5a0 0
05 0700 0000 1 1 7 1357 1357 a5a0 0
05 0700 0000 1 0 0 0000 1357 a5a0 0
05 3f00 81c4 1 0 0 0000 81c6 a5a0 1
05 0700 0000 1 1 7 2468 2468 a5a0 0
05 0700 0000 1 0 0 0000 2468 a5a0 0
05 0700 0000 1 1 7 dead 2468 a5a0 0
05 0700 0000 1 0 0 0000 2468 a5a0 0
// Test 6: link with a writeback in the same cycle, link wins on r7
06 33e0 2f70 1 1 3 6789 6789 2f72 1
06 03e0 0000 1 0 0 0000 6789 2f72 0
06 3700 d0a6 1 1 7 1111 d0a8 a5a0 1
06 03e0 0000 1 1 7 eeee 6789 d0a8 0
06 03e0 0000 1 0 0 0000 6789 d0a8 0
06 03e0 0000 1 1 7 ffff 6789 d0a8 0
06 03e0 0000 1 0 0 0000 6789 d0a8 0
ffff 0000 0000 0 0 0 0000 0000 0000 0
